// ==== verilog/stream_mux_macros.svh ====
`ifndef STREAM_MUX_MACROS_SVH
`define STREAM_MUX_MACROS_SVH

// Number of byte streams into the interleaver
`define NUM_STREAMS 8

// Bytes buffered per stream
`define FIFO_DEPTH 16

// Pointer width for one FIFO
// Must be log2 of the depth so that pointers wrap on their own
`define FIFO_PTR_W 4

// Output channel code of the AT command path
// Top bit set marks it apart from any stream index
`define AT_SEL 4'b1000

`endif

// ==== verilog/stream_mux_pkg.sv ====
`include "stream_mux_macros.svh"

package stream_mux_pkg;

	typedef logic [7:0] stream_byte_t;              // One payload byte
	typedef logic [2:0] stream_idx_t;               // Stream number
	typedef logic [`NUM_STREAMS-1:0] stream_mask_t; // One bit per stream
	typedef logic [3:0] mux_sel_t;                  // Bit 3 flags AT and bits 2..0 hold the index
	typedef logic [9:0] dwell_t;                    // Dwell cap and count

	// Scheduler states
	typedef enum logic [2:0] {
		SW_IDLE = 3'b000,
		SW_LOAD = 3'b001,
		SW_FIND = 3'b010,
		SW_RUN  = 3'b011,
		SW_AT   = 3'b111
	} switch_state_t;

	// Switch to output stage
	typedef struct packed {
		logic     ready; // Grant is live
		mux_sel_t sel;   // Granted channel
	} stream_grant_t;

	// Registered output word
	typedef struct packed {
		mux_sel_t     sel;  // Channel tag
		stream_byte_t data; // Payload
	} tx_word_t;

endpackage

// ==== verilog/stream_fifo.sv ====
`timescale 1ns/10ps
`include "stream_mux_macros.svh"

module stream_fifo (
	input  logic                         clock,
	input  logic                         resetn,
	input  logic                         wr_i,   // Write strobe
	input  stream_mux_pkg::stream_byte_t data_i,
	input  logic                         pop_i,  // Remove head
	output stream_mux_pkg::stream_byte_t data_o, // Head byte, fall-through
	output logic                         empty_o,
	output logic                         full_o
);
	import stream_mux_pkg::*;

	stream_byte_t           mem [`FIFO_DEPTH]; // Byte storage
	logic [`FIFO_PTR_W-1:0] wr_ptr;
	logic [`FIFO_PTR_W-1:0] rd_ptr;
	logic [`FIFO_PTR_W:0]   count;  // Extra bit so 16 fits
	logic                   do_wr;  // Accepted write
	logic                   do_pop; // Accepted pop

	// Status from occupancy only
	assign empty_o = (count == '0);
	assign full_o  = (count == (`FIFO_PTR_W+1)'(`FIFO_DEPTH));

	// Drop on full, ignore pop on empty
	assign do_wr  = wr_i && !full_o;
	assign do_pop = pop_i && !empty_o;

	// Head is visible without a read cycle
	assign data_o = mem[rd_ptr];

	// Storage write
	always_ff @(posedge clock)
	begin
		if (do_wr)
			mem[wr_ptr] <= data_i;
	end

	// Pointers wrap naturally at the depth
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Occupancy, both strobes together leave it unchanged
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			count <= '0;
		else
		begin
			case ({do_wr, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== verilog/master_switch.sv ====
`timescale 1ns/10ps
`include "stream_mux_macros.svh"

module master_switch (
	input  logic                          clock,
	input  logic                          resetn,
	input  stream_mux_pkg::dwell_t        timer_cap_i,        // Dwell is cap+1 cycles
	input  logic                          want_at_i,          // AT bypass request
	input  logic                          sending_i,          // Hold to keep sending
	input  stream_mux_pkg::stream_mask_t  selected_streams_i,
	input  stream_mux_pkg::stream_mask_t  empty_i,            // Live FIFO empty flags
	output stream_mux_pkg::stream_grant_t grant_o
);
	import stream_mux_pkg::*;

	switch_state_t state_q;
	switch_state_t state_d;
	stream_mask_t  mask_q;  // Rotating selection, bit 0 tracks idx_q
	stream_idx_t   idx_q;   // Stream under inspection
	dwell_t        timer_q; // Cycles spent in the current dwell

	logic cur_selected; // Current stream is in the selection
	logic cur_empty;    // Current stream has nothing to send
	logic skip;         // Move past current stream while searching
	logic dwell_done;   // Last cycle of the dwell window
	logic advance;      // Step mask and index together

	assign cur_selected = mask_q[0];
	assign cur_empty    = empty_i[idx_q];
	assign dwell_done   = (timer_q == timer_cap_i);

	// Unselected or empty both mean look at the next one
	assign skip    = (state_q == SW_FIND) && (!cur_selected || cur_empty);
	assign advance = skip || ((state_q == SW_RUN) && dwell_done);

	// Next state
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			SW_IDLE:
			begin
				if (sending_i)
					state_d = want_at_i ? SW_AT : SW_LOAD;
			end
			SW_AT:
			begin
				if (!sending_i)
					state_d = SW_IDLE; // Bypass ends with sending
			end
			SW_LOAD:
				state_d = SW_FIND; // Single cycle mask load
			SW_FIND:
			begin
				if (!sending_i)
					state_d = SW_IDLE;
				else if (cur_selected && !cur_empty)
					state_d = SW_RUN;
			end
			SW_RUN:
			begin
				// Dwell runs to the cap regardless of sending
				if (dwell_done)
					state_d = SW_FIND;
			end
			default:
				state_d = SW_IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			state_q <= SW_IDLE;
		else
			state_q <= state_d;
	end

	// Selection mask, rotates right so service is 0,1..7,0
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			mask_q <= '0;
		else if (state_q == SW_IDLE)
			mask_q <= '0;
		else if (state_q == SW_LOAD)
			mask_q <= selected_streams_i; // Fresh copy each session
		else if (advance)
			mask_q <= {mask_q[0], mask_q[`NUM_STREAMS-1:1]};
	end

	// Stream index, kept in step with mask bit 0
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			idx_q <= '0;
		else if ((state_q == SW_IDLE) || (state_q == SW_LOAD))
			idx_q <= '0;
		else if (advance)
			idx_q <= idx_q + 1'b1; // Wraps 7 to 0
	end

	// Dwell timer
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			timer_q <= '0;
		else if (state_q == SW_FIND)
			timer_q <= '0; // Start of every dwell sees zero
		else if (state_q == SW_RUN)
			timer_q <= timer_q + 1'b1;
	end

	// Grant to output stage
	always_comb
	begin
		grant_o.ready = 1'b0;
		grant_o.sel   = {1'b0, idx_q};
		case (state_q)
			SW_AT:
			begin
				grant_o.ready = 1'b1;
				grant_o.sel   = `AT_SEL;
			end
			SW_RUN:
				grant_o.ready = 1'b1; // Stream path, sel is the index
			default:
				grant_o.ready = 1'b0;
		endcase
	end

endmodule

// ==== verilog/tx_output_stage.sv ====
`timescale 1ns/10ps
`include "stream_mux_macros.svh"

module tx_output_stage (
	input  logic                                            clock,
	input  logic                                            resetn,
	input  stream_mux_pkg::stream_grant_t                   grant_i,
	input  stream_mux_pkg::stream_mask_t                    empty_i,
	input  stream_mux_pkg::stream_byte_t [`NUM_STREAMS-1:0] head_i,    // FIFO heads
	input  stream_mux_pkg::stream_byte_t                    at_data_i, // AT command byte
	input  logic                                            at_valid_i,
	output stream_mux_pkg::stream_mask_t                    pop_o,     // One-hot pop
	output stream_mux_pkg::tx_word_t                        tx_word_o,
	output logic                                            tx_valid_o
);
	import stream_mux_pkg::*;

	stream_idx_t idx;        // Granted stream
	logic        at_path;    // AT bypass owns the output
	logic        stream_pop; // Granted FIFO pops this cycle
	logic        at_fire;    // AT byte taken this cycle

	assign idx        = grant_i.sel[2:0];
	assign at_path    = grant_i.ready && (grant_i.sel == `AT_SEL);
	assign stream_pop = grant_i.ready && !grant_i.sel[3] && !empty_i[idx];
	assign at_fire    = at_path && at_valid_i;

	// Pop only the granted stream, and only if it holds data
	always_comb
	begin
		pop_o      = '0;
		pop_o[idx] = stream_pop;
	end

	// One valid per pop or AT strobe
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			tx_valid_o <= 1'b0;
		else
			tx_valid_o <= stream_pop || at_fire;
	end

	// Output word, head byte leaves as the FIFO pops
	always_ff @(posedge clock)
	begin
		if (at_fire)
		begin
			tx_word_o.sel  <= `AT_SEL;
			tx_word_o.data <= at_data_i;
		end
		else if (stream_pop)
		begin
			tx_word_o.sel  <= grant_i.sel; // Tag with channel
			tx_word_o.data <= head_i[idx];
		end
	end

endmodule

// ==== verilog/stream_mux_top.sv ====
`timescale 1ns/10ps
`include "stream_mux_macros.svh"

module stream_mux_top (
	input  logic                                            clock,
	input  logic                                            resetn,
	// Input side
	input  stream_mux_pkg::stream_mask_t                    stream_wr_i,   // Per-stream write strobes
	input  stream_mux_pkg::stream_byte_t [`NUM_STREAMS-1:0] stream_data_i,
	output stream_mux_pkg::stream_mask_t                    stream_full_o,
	// Scheduler control
	input  stream_mux_pkg::stream_mask_t                    selected_streams_i,
	input  stream_mux_pkg::dwell_t                          timer_cap_i,
	input  logic                                            want_at_i,
	input  logic                                            sending_i,
	// AT command source
	input  stream_mux_pkg::stream_byte_t                    at_data_i,
	input  logic                                            at_valid_i,
	// Output side
	output logic                                            select_ready_o,
	output stream_mux_pkg::tx_word_t                        tx_word_o,
	output logic                                            tx_valid_o
);
	import stream_mux_pkg::*;

	stream_mask_t                    fifo_empty; // Live empty flags
	stream_mask_t                    fifo_pop;   // From output stage
	stream_byte_t [`NUM_STREAMS-1:0] fifo_head;  // Fall-through heads
	stream_grant_t                   grant;      // Switch decision

	// One FIFO per stream
	genvar g;
	generate
		for (g = 0; g < `NUM_STREAMS; g++)
		begin : g_fifo
			stream_fifo u_fifo (
				.clock   (clock),
				.resetn  (resetn),
				.wr_i    (stream_wr_i[g]),
				.data_i  (stream_data_i[g]),
				.pop_i   (fifo_pop[g]),
				.data_o  (fifo_head[g]),
				.empty_o (fifo_empty[g]),
				.full_o  (stream_full_o[g])
			);
		end
	endgenerate

	// Scheduler
	master_switch u_switch (
		.clock              (clock),
		.resetn             (resetn),
		.timer_cap_i        (timer_cap_i),
		.want_at_i          (want_at_i),
		.sending_i          (sending_i),
		.selected_streams_i (selected_streams_i),
		.empty_i            (fifo_empty),
		.grant_o            (grant)
	);

	// Pop decode and registered output
	tx_output_stage u_out (
		.clock      (clock),
		.resetn     (resetn),
		.grant_i    (grant),
		.empty_i    (fifo_empty),
		.head_i     (fifo_head),
		.at_data_i  (at_data_i),
		.at_valid_i (at_valid_i),
		.pop_o      (fifo_pop),
		.tx_word_o  (tx_word_o),
		.tx_valid_o (tx_valid_o)
	);

	assign select_ready_o = grant.ready; // Straight from the switch

endmodule

// ==== testbench/tb_stream_mux.sv ====
`timescale 1ns/10ps
`include "stream_mux_macros.svh"

module tb_stream_mux;
	import stream_mux_pkg::*;

	logic                            clock = 1'b0;
	logic                            resetn;
	stream_mask_t                    stream_wr;
	stream_byte_t [`NUM_STREAMS-1:0] stream_data;
	stream_mask_t                    stream_full;
	stream_mask_t                    selected_streams;
	dwell_t                          timer_cap;
	logic                            want_at;
	logic                            sending;
	stream_byte_t                    at_data;
	logic                            at_valid;
	logic                            select_ready;
	tx_word_t                        tx_word;
	logic                            tx_valid;

	stream_byte_t model_data [`NUM_STREAMS][64]; // Model FIFOs as rings
	int           model_wr [`NUM_STREAMS];       // Free-running write count
	int           model_rd [`NUM_STREAMS];
	tx_word_t     exp_q [$];                     // Predicted output order
	tx_word_t     got_q [$];                     // As seen on the DUT

	logic [31:0] rng_state = 32'd87745;
	int          errors = 0;
	int          test_errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          cycles = 0;
	int          cycle_limit = 200; // Reset allowance
	string       cur_test = "reset";

	stream_mux_top uut (
		.clock              (clock),
		.resetn             (resetn),
		.stream_wr_i        (stream_wr),
		.stream_data_i      (stream_data),
		.stream_full_o      (stream_full),
		.selected_streams_i (selected_streams),
		.timer_cap_i        (timer_cap),
		.want_at_i          (want_at),
		.sending_i          (sending),
		.at_data_i          (at_data),
		.at_valid_i         (at_valid),
		.select_ready_o     (select_ready),
		.tx_word_o          (tx_word),
		.tx_valid_o         (tx_valid)
	);

	always #4 clock = ~clock; // 8 ns period

	// Output capture on the falling edge, away from the DUT update
	always @(negedge clock)
	begin
		if (tx_valid)
			got_q.push_back(tx_word);
	end

	// Watchdog
	always @(posedge clock)
	begin
		cycles++;
		if (cycles > cycle_limit)
		begin
			$display("timeout in %s after %0d cycles, only %0d of %0d expected words arrived",
				cur_test, cycles, got_q.size(), exp_q.size());
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// LCG, Numerical Recipes constants
	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = next_rand();
		return int'(r[31:8] % n); // Low bits of an LCG are weak
	endfunction

	function automatic int model_count(input int s);
		return model_wr[s] - model_rd[s];
	endfunction

	task automatic check_word(input string name, input int pos, input tx_word_t expected,
		input tx_word_t actual);
		if (expected !== actual)
		begin
			$display("mismatch in %s word %0d: expected sel %h data %h, actual sel %h data %h",
				name, pos, expected.sel, expected.data, actual.sel, actual.data);
			test_errors++;
		end
	endtask

	task automatic check_full(input string name, input stream_mask_t expected,
		input stream_mask_t actual);
		if (expected !== actual)
		begin
			$display("mismatch in %s full flags: expected %b, actual %b", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic begin_test(input string name, input int nbytes, input int cap);
		cur_test = name;
		test_errors = 0;
		got_q.delete();
		exp_q.delete();
		cycle_limit = cycles + nbytes * (cap + 10) + 200;
	endtask

	task automatic finish_test();
		tests_run++;
		errors += test_errors;
		if (test_errors == 0)
			$display("test %s: ok, %0d words", cur_test, got_q.size());
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", cur_test, test_errors);
		end
	endtask

	// One write per cycle, model drops on full like the FIFO
	task automatic push_byte(input int s, input stream_byte_t b);
		@(posedge clock);
		stream_wr <= stream_mask_t'(1 << s);
		stream_data[s] <= b;
		if (model_count(s) < `FIFO_DEPTH)
		begin
			model_data[s][model_wr[s] % 64] = b;
			model_wr[s]++;
		end
	endtask

	task automatic preload(input int s, input int len);
		for (int i = 0; i < len; i++)
			push_byte(s, stream_byte_t'(rand_below(256)));
	endtask

	task automatic release_inputs();
		@(posedge clock);
		stream_wr <= '0;
		at_valid  <= 1'b0;
	endtask

	// Ascending cyclic walk from 0, up to cap+1 bytes per visit
	task automatic predict_walk(input stream_mask_t mask, input int cap);
		int       idx;
		int       take;
		int       pending;
		tx_word_t w;
		exp_q.delete();
		idx = 0;
		pending = 0;
		for (int s = 0; s < `NUM_STREAMS; s++)
			if (mask[s])
				pending += model_count(s);
		while (pending > 0)
		begin
			if (mask[idx] && model_count(idx) > 0)
			begin
				take = (model_count(idx) < cap + 1) ? model_count(idx) : cap + 1;
				for (int k = 0; k < take; k++)
				begin
					w.sel  = {1'b0, stream_idx_t'(idx)};
					w.data = model_data[idx][model_rd[idx] % 64];
					exp_q.push_back(w);
					model_rd[idx]++;
				end
				pending -= take;
			end
			idx = (idx + 1) % `NUM_STREAMS;
		end
	endtask

	task automatic stop_sending(input int cap);
		int waited;
		@(posedge clock);
		sending <= 1'b0;
		want_at <= 1'b0;
		waited = 0;
		do
		begin
			@(negedge clock);
			waited++;
		end
		while (select_ready && waited < cap + 20); // RUN finishes its dwell first
		if (select_ready)
		begin
			$display("%s: select_ready_o still high %0d cycles after sending dropped",
				cur_test, waited);
			test_errors++;
		end
		repeat (3) @(posedge clock); // Back to idle
	endtask

	task automatic compare_words();
		for (int i = 0; i < exp_q.size(); i++)
			check_word(cur_test, i, exp_q[i], got_q[i]);
		if (got_q.size() > exp_q.size())
		begin
			$display("%s: %0d output words arrived, only %0d were expected",
				cur_test, got_q.size(), exp_q.size());
			test_errors++;
		end
	endtask

	task automatic drain_and_compare(input stream_mask_t mask, input int cap);
		predict_walk(mask, cap);
		got_q.delete();
		@(posedge clock);
		selected_streams <= mask;
		timer_cap        <= dwell_t'(cap);
		want_at          <= 1'b0;
		sending          <= 1'b1;
		while (got_q.size() < exp_q.size())
			@(posedge clock);
		repeat (2 * (cap + 1) + 16) @(posedge clock); // Stray words would show here
		stop_sending(cap);
		compare_words();
		foreach (got_q[i])
		begin
			if (got_q[i].sel[3] || !mask[got_q[i].sel[2:0]])
			begin
				$display("%s: word %0d came from channel %h, which is not selected",
					cur_test, i, got_q[i].sel);
				test_errors++;
			end
		end
	endtask

	task automatic round_robin_test();
		int len [`NUM_STREAMS];
		int total;
		int cap;
		total = 0;
		for (int s = 0; s < `NUM_STREAMS; s++)
		begin
			len[s] = rand_below(13);
			total += len[s];
		end
		cap = rand_below(4);
		begin_test("round_robin", total, cap);
		for (int s = 0; s < `NUM_STREAMS; s++)
			preload(s, len[s]);
		release_inputs();
		@(negedge clock);
		check_full(cur_test, '0, stream_full); // Twelve at most, never full
		drain_and_compare('1, cap);
		finish_test();
	endtask

	// Unselected bytes stay behind for the next test
	task automatic partial_mask_test();
		stream_mask_t mask;
		int           pick;
		int           cap;
		mask = stream_mask_t'(rand_below(256));
		pick = rand_below(`NUM_STREAMS);
		mask[pick] = 1'b1;
		mask[(pick + 4) % `NUM_STREAMS] = 1'b0;
		cap = rand_below(4);
		begin_test("partial_mask", 64, cap);
		for (int s = 0; s < `NUM_STREAMS; s++)
			preload(s, 1 + rand_below(8));
		release_inputs();
		drain_and_compare(mask, cap);
		finish_test();
	endtask

	task automatic empty_skip_test();
		int hole;
		int cap;
		hole = -1;
		for (int s = 0; s < `NUM_STREAMS; s++)
			if (hole < 0 && model_count(s) == 0)
				hole = s; // Left empty on purpose
		cap = 20 + rand_below(20); // Cap exceeds any stream length
		begin_test("empty_skip", 128, cap);
		for (int s = 0; s < `NUM_STREAMS; s++)
			if (s != hole && rand_below(2) == 1)
				preload(s, 1 + rand_below(8));
		release_inputs();
		drain_and_compare('1, cap);
		finish_test();
	endtask

	task automatic overflow_test();
		int s;
		int cap;
		s = rand_below(`NUM_STREAMS);
		cap = rand_below(8);
		begin_test("overflow", 36, cap);
		preload(s, 20); // Last four are dropped
		release_inputs();
		@(negedge clock);
		check_full(cur_test, stream_mask_t'(1 << s), stream_full);
		drain_and_compare('1, cap);
		@(negedge clock);
		check_full(cur_test, '0, stream_full);
		finish_test();
	endtask

	task automatic at_bypass_test();
		int           n;
		int           gap;
		stream_byte_t b;
		tx_word_t     w;
		n = 4 + rand_below(7);
		begin_test("at_bypass", n + 8, 1);
		preload(rand_below(`NUM_STREAMS), 1 + rand_below(4)); // Must not leak out
		release_inputs();
		@(posedge clock);
		selected_streams <= '1;
		want_at          <= 1'b1;
		sending          <= 1'b1;
		do
			@(negedge clock);
		while (!select_ready);
		for (int i = 0; i < n; i++)
		begin
			b = stream_byte_t'(rand_below(256));
			w.sel  = `AT_SEL;
			w.data = b;
			exp_q.push_back(w);
			gap = rand_below(3);
			@(posedge clock);
			at_data  <= b;
			at_valid <= 1'b1;
			@(posedge clock);
			at_valid <= 1'b0;
			repeat (gap) @(posedge clock);
		end
		while (got_q.size() < n)
			@(posedge clock);
		repeat (4) @(posedge clock);
		stop_sending(0);
		compare_words();
		drain_and_compare('1, 1); // FIFO bytes survived the bypass
		finish_test();
	endtask

	initial
	begin
		resetn           = 1'b0;
		stream_wr        = '0;
		stream_data      = '0;
		selected_streams = '0;
		timer_cap        = '0;
		want_at          = 1'b0;
		sending          = 1'b0;
		at_data          = '0;
		at_valid         = 1'b0;
		repeat (2) @(posedge clock);
		resetn <= 1'b1;
		@(posedge clock);
		round_robin_test();
		partial_mask_test();
		empty_skip_test();
		overflow_test();
		at_bypass_test();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+verilog
verilog/stream_mux_pkg.sv
verilog/stream_fifo.sv
verilog/master_switch.sv
verilog/tx_output_stage.sv
verilog/stream_mux_top.sv
testbench/tb_stream_mux.sv

// ==== Bender.yml ====
package:
  name: stream_mux

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/stream_mux_pkg.sv
      - verilog/stream_fifo.sv
      - verilog/master_switch.sv
      - verilog/tx_output_stage.sv
      - verilog/stream_mux_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_stream_mux.sv
